// File: verilog/ext_mem_pkg.sv
package ext_mem_pkg;

   // Native bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // Cache geometry, one word per line
   localparam int idx_w = 4;          // 16 lines
   localparam int off_w = 2;          // Byte within the word
   localparam int tag_w = addr_w - idx_w - off_w;

   // Cache address, seen either as a plain byte address or split
   // into the fields a direct-mapped lookup needs
   typedef union packed {
      logic [addr_w-1:0] raw;
      struct packed {
         logic [tag_w-1:0] tag;
         logic [idx_w-1:0] idx;
         logic [off_w-1:0] off;
      } f;
   } cache_addr_u;

endpackage

// File: verilog/mem_cache.sv
module mem_cache (
   input  logic                            clk,
   input  logic                            arst_n,

   // Front-end bus
   input  logic                            valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  addr,
   input  logic [ext_mem_pkg::data_w-1:0]  wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  wstrb,
   output logic [ext_mem_pkg::data_w-1:0]  rdata,
   output logic                            ready,

   // Back-end bus
   output logic                            be_valid,
   output logic [ext_mem_pkg::addr_w-1:0]  be_addr,
   output logic [ext_mem_pkg::data_w-1:0]  be_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]  be_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]  be_rdata,
   input  logic                            be_ready
);

   import ext_mem_pkg::*;

   localparam int n_lines = 1 << idx_w;

   // Controller states
   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_be   = 2'd1;   // Waiting on memory
   localparam logic [1:0] st_resp = 2'd2;   // Ready to the front-end

   logic [1:0]         state;
   logic [n_lines-1:0] line_vld;
   logic [tag_w-1:0]   tag_mem [n_lines];
   logic [data_w-1:0]  data_mem [n_lines];

   cache_addr_u        in_addr;             // Address on the front-end
   cache_addr_u        req_addr;            // Address of the request in flight
   logic [data_w-1:0]  req_wdata;
   logic [strb_w-1:0]  req_wstrb;

   logic               accept;
   logic               in_rd_hit;
   logic               req_hit;
   logic               req_write;
   logic               be_done;

   assign in_addr = addr;

   assign accept    = (state == st_idle) && valid;
   assign req_write = |req_wstrb;
   assign be_done   = (state == st_be) && be_ready;

   // Lookup at acceptance decides between the fast path and memory
   assign in_rd_hit = !(|wstrb) && line_vld[in_addr.f.idx] &&
                      (tag_mem[in_addr.f.idx] == in_addr.f.tag);

   // Lookup on the captured request, used to merge write data
   assign req_hit = line_vld[req_addr.f.idx] &&
                    (tag_mem[req_addr.f.idx] == req_addr.f.tag);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= st_idle;
         line_vld <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  state <= in_rd_hit ? st_resp : st_be;
               end
            end
            st_be: begin
               if (be_ready) begin
                  state <= st_resp;
                  if (!req_write) begin
                     line_vld[req_addr.f.idx] <= 1'b1;   // Line filled
                  end
               end
            end
            default: state <= st_idle;   // One response cycle
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr.raw <= addr;
         req_wdata    <= wdata;
         req_wstrb    <= wstrb;
         rdata        <= data_mem[in_addr.f.idx];   // Used on a hit
      end

      if (be_done) begin
         rdata <= be_rdata;
         if (!req_write) begin
            tag_mem[req_addr.f.idx]  <= req_addr.f.tag;
            data_mem[req_addr.f.idx] <= be_rdata;
         end else if (req_hit) begin
            // Write-through hit keeps the line in step with memory
            for (int b = 0; b < strb_w; b++) begin
               if (req_wstrb[b]) begin
                  data_mem[req_addr.f.idx][8*b +: 8] <= req_wdata[8*b +: 8];
               end
            end
         end
      end
   end

   assign ready = (state == st_resp);

   // Every miss and every write goes out unchanged
   assign be_valid = (state == st_be);
   assign be_addr  = req_addr.raw;
   assign be_wdata = req_wdata;
   assign be_wstrb = req_wstrb;

endmodule

// File: verilog/bus_merge.sv
module bus_merge (
   input  logic                            clk,
   input  logic                            arst_n,

   // Port 0, instruction cache back-end
   input  logic                            p0_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  p0_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  p0_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  p0_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]  p0_rdata,
   output logic                            p0_ready,

   // Port 1, data cache back-end
   input  logic                            p1_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  p1_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  p1_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  p1_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]  p1_rdata,
   output logic                            p1_ready,

   // Shared memory port
   output logic                            mem_valid,
   output logic [ext_mem_pkg::addr_w-1:0]  mem_addr,
   output logic [ext_mem_pkg::data_w-1:0]  mem_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]  mem_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]  mem_rdata,
   input  logic                            mem_ready
);

   import ext_mem_pkg::*;

   localparam int req_w = addr_w + data_w + strb_w;

   logic             locked;   // A transfer is under way
   logic             owner;    // Port holding the grant
   logic             sel;
   logic [req_w-1:0] p0_req;
   logic [req_w-1:0] p1_req;

   // A free port goes to the data side first
   assign sel = locked ? owner : p1_valid;

   assign p0_req = {p0_addr, p0_wdata, p0_wstrb};
   assign p1_req = {p1_addr, p1_wdata, p1_wstrb};

   assign mem_valid = sel ? p1_valid : p0_valid;
   assign {mem_addr, mem_wdata, mem_wstrb} = sel ? p1_req : p0_req;

   // Grant lasts until memory answers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         locked <= 1'b0;
         owner  <= 1'b0;
      end else begin
         locked <= mem_valid && !mem_ready;
         owner  <= sel;
      end
   end

   assign p0_ready = mem_ready && !sel;
   assign p1_ready = mem_ready && sel;

   assign p0_rdata = mem_rdata;   // Only the owner sees ready
   assign p1_rdata = mem_rdata;

endmodule

// File: verilog/ext_mem.sv
module ext_mem (
   input  logic                            clk,
   input  logic                            arst_n,

   // Instruction bus
   input  logic                            i_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  i_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  i_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  i_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]  i_rdata,
   output logic                            i_ready,

   // Data bus
   input  logic                            d_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  d_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  d_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  d_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]  d_rdata,
   output logic                            d_ready,

   // Memory bus
   output logic                            mem_valid,
   output logic [ext_mem_pkg::addr_w-1:0]  mem_addr,
   output logic [ext_mem_pkg::data_w-1:0]  mem_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]  mem_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]  mem_rdata,
   input  logic                            mem_ready
);

   import ext_mem_pkg::*;

   // Instruction cache back-end
   logic              ic_be_valid;
   logic [addr_w-1:0] ic_be_addr;
   logic [data_w-1:0] ic_be_wdata;
   logic [strb_w-1:0] ic_be_wstrb;
   logic [data_w-1:0] ic_be_rdata;
   logic              ic_be_ready;

   // Data cache back-end
   logic              dc_be_valid;
   logic [addr_w-1:0] dc_be_addr;
   logic [data_w-1:0] dc_be_wdata;
   logic [strb_w-1:0] dc_be_wstrb;
   logic [data_w-1:0] dc_be_rdata;
   logic              dc_be_ready;

   mem_cache u_icache (
      .clk      (clk),
      .arst_n   (arst_n),
      .valid    (i_valid),
      .addr     (i_addr),
      .wdata    (i_wdata),
      .wstrb    (i_wstrb),
      .rdata    (i_rdata),
      .ready    (i_ready),
      .be_valid (ic_be_valid),
      .be_addr  (ic_be_addr),
      .be_wdata (ic_be_wdata),
      .be_wstrb (ic_be_wstrb),
      .be_rdata (ic_be_rdata),
      .be_ready (ic_be_ready)
   );

   mem_cache u_dcache (
      .clk      (clk),
      .arst_n   (arst_n),
      .valid    (d_valid),
      .addr     (d_addr),
      .wdata    (d_wdata),
      .wstrb    (d_wstrb),
      .rdata    (d_rdata),
      .ready    (d_ready),
      .be_valid (dc_be_valid),
      .be_addr  (dc_be_addr),
      .be_wdata (dc_be_wdata),
      .be_wstrb (dc_be_wstrb),
      .be_rdata (dc_be_rdata),
      .be_ready (dc_be_ready)
   );

   // Data side on port 1 for priority
   bus_merge u_merge (
      .clk       (clk),
      .arst_n    (arst_n),
      .p0_valid  (ic_be_valid),
      .p0_addr   (ic_be_addr),
      .p0_wdata  (ic_be_wdata),
      .p0_wstrb  (ic_be_wstrb),
      .p0_rdata  (ic_be_rdata),
      .p0_ready  (ic_be_ready),
      .p1_valid  (dc_be_valid),
      .p1_addr   (dc_be_addr),
      .p1_wdata  (dc_be_wdata),
      .p1_wstrb  (dc_be_wstrb),
      .p1_rdata  (dc_be_rdata),
      .p1_ready  (dc_be_ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

// File: verification/clk_gen.sv
module clk_gen (
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam time half_period = 10ns;   // 20 ns clock
   localparam int  reset_cycles = 10;

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk) arst_n = 1'b1;
   end

endmodule

// File: verification/ext_mem_checker.sv
module ext_mem_checker (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            i_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  i_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  i_rdata,
   input  logic                            i_ready,
   input  logic                            d_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  d_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  d_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  d_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]  d_rdata,
   input  logic                            d_ready,
   input  logic                            mem_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]  mem_addr,
   input  logic [ext_mem_pkg::data_w-1:0]  mem_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]  mem_wstrb,
   input  logic                            mem_ready,
   input  int                              step,
   input  logic [ext_mem_pkg::data_w-1:0]  exp_i,
   input  logic [ext_mem_pkg::data_w-1:0]  exp_d,
   output int                              rd_errors,
   output int                              proto_errors
);

   timeunit 1ns;
   timeprecision 1ps;

   import ext_mem_pkg::*;

   // Tag shadows of both caches
   logic [tag_w-1:0]     i_tag [1 << idx_w];
   logic [tag_w-1:0]     d_tag [1 << idx_w];
   logic [(1<<idx_w)-1:0] i_vld;
   logic [(1<<idx_w)-1:0] d_vld;

   cache_addr_u       ia;
   cache_addr_u       da;
   logic              seen_req, i_busy, d_busy, i_hit, d_hit, race, i_start;
   logic [data_w-1:0] i_exp, d_exp, d_cap_wdata;
   logic [strb_w-1:0] d_cap_strb;
   int                i_mem, d_mem, i_step, d_step, exp_cnt;

   always @(posedge clk) begin
      if (!arst_n) begin
         seen_req = 1'b0;
         i_busy   = 1'b0;
         d_busy   = 1'b0;
         race     = 1'b0;
         i_vld    = '0;
         d_vld    = '0;
      end else begin
         // Quiet outputs until the first request
         if (!seen_req) begin
            if (i_valid || d_valid) begin
               seen_req = 1'b1;
            end else if (i_ready || d_ready || mem_valid) begin
               proto_errors++;
               $display("Output active after reset before any request");
            end
         end

         if (mem_valid && mem_ready) begin
            if (race && mem_addr != da.raw) begin   // Data side wins
               proto_errors++;
               $display("[ERROR] step_%0d first_mem_addr: expected %h, actual %h",
                        d_step, da.raw, mem_addr);
            end
            race = 1'b0;
            if (i_busy && mem_addr == ia.raw) begin
               i_mem++;
               if (mem_wstrb != '0) begin
                  proto_errors++;
                  $display("Instruction fetch reached memory as a write");
               end
            end else if (d_busy && mem_addr == da.raw) begin
               d_mem++;
               if (mem_wstrb != d_cap_strb ||
                   (d_cap_strb != '0 && mem_wdata != d_cap_wdata)) begin
                  proto_errors++;
                  $display("[ERROR] step_%0d mem_write: expected %h/%h, actual %h/%h",
                           d_step, d_cap_wdata, d_cap_strb, mem_wdata, mem_wstrb);
               end
            end else begin
               proto_errors++;
               $display("Memory transaction at %h matches no open request", mem_addr);
            end
         end

         i_start = 1'b0;
         if (i_busy && i_ready) begin
            i_busy = 1'b0;
            if (i_rdata !== i_exp) begin
               rd_errors++;
               $display("[ERROR] step_%0d i_rdata: expected %h, actual %h",
                        i_step, i_exp, i_rdata);
            end
            exp_cnt = i_hit ? 0 : 1;
            if (i_mem != exp_cnt) begin
               proto_errors++;
               $display("[ERROR] step_%0d i_mem_count: expected %0d, actual %0d",
                        i_step, exp_cnt, i_mem);
            end
            i_vld[ia.f.idx] = 1'b1;
            i_tag[ia.f.idx] = ia.f.tag;
         end else if (!i_busy && i_valid) begin
            i_busy  = 1'b1;
            i_start = 1'b1;
            ia.raw  = i_addr;
            i_exp   = exp_i;
            i_step  = step;
            i_mem   = 0;
            i_hit   = i_vld[ia.f.idx] && (i_tag[ia.f.idx] == ia.f.tag);
         end else if (i_ready) begin
            proto_errors++;
            $display("Instruction ready without an open request");
         end

         if (d_busy && d_ready) begin
            d_busy = 1'b0;
            if (d_cap_strb == '0) begin
               if (d_rdata !== d_exp) begin
                  rd_errors++;
                  $display("[ERROR] step_%0d d_rdata: expected %h, actual %h",
                           d_step, d_exp, d_rdata);
               end
               d_vld[da.f.idx] = 1'b1;
               d_tag[da.f.idx] = da.f.tag;
            end
            exp_cnt = d_hit ? 0 : 1;
            if (d_mem != exp_cnt) begin
               proto_errors++;
               $display("[ERROR] step_%0d d_mem_count: expected %0d, actual %0d",
                        d_step, exp_cnt, d_mem);
            end
         end else if (!d_busy && d_valid) begin
            d_busy      = 1'b1;
            da.raw      = d_addr;
            d_exp       = exp_d;
            d_cap_wdata = d_wdata;
            d_cap_strb  = d_wstrb;
            d_step      = step;
            d_mem       = 0;
            // Writes always go to memory
            d_hit = (d_wstrb == '0) && d_vld[da.f.idx] && (d_tag[da.f.idx] == da.f.tag);
            race  = i_start && !i_hit && !d_hit;
         end else if (d_ready) begin
            proto_errors++;
            $display("Data ready without an open request");
         end
      end
   end

endmodule

// File: verification/ext_mem_assertions.sv
module ext_mem_assertions (
   input logic                            clk,
   input logic                            arst_n,
   input logic                            i_valid,
   input logic                            i_ready,
   input logic                            d_valid,
   input logic                            d_ready,
   input logic                            mem_valid,
   input logic [ext_mem_pkg::addr_w-1:0]  mem_addr,
   input logic                            mem_ready
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // Count of failed assertions

   i_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      i_valid && !i_ready |=> i_valid)
      else begin
         fail_cnt++;
         $error("i_valid dropped before i_ready");
      end
   d_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      d_valid && !d_ready |=> d_valid)
      else begin
         fail_cnt++;
         $error("d_valid dropped before d_ready");
      end
   mem_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && !mem_ready |=> mem_valid)
      else begin
         fail_cnt++;
         $error("mem_valid dropped early");
      end

   i_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      i_ready |=> !i_ready)
      else begin
         fail_cnt++;
         $error("i_ready longer than one cycle");
      end
   d_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      d_ready |=> !d_ready)
      else begin
         fail_cnt++;
         $error("d_ready longer than one cycle");
      end

   // Arbiter holds the granted request until memory answers
   mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && !mem_ready |=> $stable(mem_addr))
      else begin
         fail_cnt++;
         $error("mem request changed without mem_ready");
      end

endmodule

bind ext_mem ext_mem_assertions u_assertions (
   .clk       (clk),
   .arst_n    (arst_n),
   .i_valid   (i_valid),
   .i_ready   (i_ready),
   .d_valid   (d_valid),
   .d_ready   (d_ready),
   .mem_valid (mem_valid),
   .mem_addr  (mem_addr),
   .mem_ready (mem_ready)
);

// File: verification/tb_ext_mem.sv
module tb_ext_mem;

   timeunit 1ns;
   timeprecision 1ps;

   import ext_mem_pkg::*;

   localparam int n_pat = 22;
   localparam int reset_cycles = 10;

   logic              clk, arst_n;
   logic              i_valid = 1'b0, d_valid = 1'b0, mem_ready = 1'b0;
   logic [addr_w-1:0] i_addr = '0, d_addr = '0, mem_addr;
   logic [data_w-1:0] i_wdata = '0, d_wdata = '0, mem_rdata = '0, mem_wdata;
   logic [strb_w-1:0] i_wstrb = '0, d_wstrb = '0, mem_wstrb;
   logic [data_w-1:0] i_rdata, d_rdata, exp_i = '0, exp_d = '0;
   logic              i_ready, d_ready, mem_valid, i_done, d_done;
   int                step = 0, rd_errors, proto_errors;

   logic [31:0]       pat [n_pat*6];
   logic [31:0]       mem [1024];        // Memory model, word addressed
   logic [9:0]        word;
   int                seed = 27;
   int                wait_left = 0;
   logic              busy = 1'b0;

   clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

   ext_mem u_ext_mem (
      .clk(clk), .arst_n(arst_n),
      .i_valid(i_valid), .i_addr(i_addr), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
      .i_rdata(i_rdata), .i_ready(i_ready),
      .d_valid(d_valid), .d_addr(d_addr), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
      .d_rdata(d_rdata), .d_ready(d_ready),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
   );

   ext_mem_checker u_checker (
      .clk(clk), .arst_n(arst_n),
      .i_valid(i_valid), .i_addr(i_addr), .i_rdata(i_rdata), .i_ready(i_ready),
      .d_valid(d_valid), .d_addr(d_addr), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
      .d_rdata(d_rdata), .d_ready(d_ready),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
      .step(step), .exp_i(exp_i), .exp_d(exp_d),
      .rd_errors(rd_errors), .proto_errors(proto_errors)
   );

   // Memory model, 0 to 3 wait cycles per request
   always @(negedge clk) begin
      if (mem_ready) begin
         mem_ready = 1'b0;
         busy      = 1'b0;
      end else if (mem_valid) begin
         if (!busy) begin
            busy      = 1'b1;
            wait_left = {$random(seed)} % 4;
         end
         if (wait_left == 0) begin
            word      = mem_addr[11:2];
            mem_rdata = mem[word];
            for (int b = 0; b < strb_w; b++) begin
               if (mem_wstrb[b]) mem[word][8*b +: 8] = mem_wdata[8*b +: 8];
            end
            mem_ready = 1'b1;
         end else begin
            wait_left--;
         end
      end
   end

   initial begin
      for (int k = 0; k < 1024; k++) begin
         mem[k] = {16'hC0DE, k[15:0]};
      end
      $readmemh("verification/ext_mem_patterns.txt", pat);
      @(posedge arst_n);
      for (int s = 0; s < n_pat; s++) begin
         @(negedge clk);
         step    = s + 1;
         i_addr  = pat[s*6];
         d_addr  = pat[s*6+1];
         d_wdata = pat[s*6+2];
         d_wstrb = pat[s*6+3][strb_w-1:0];
         exp_i   = pat[s*6+4];
         exp_d   = pat[s*6+5];
         i_valid = 1'b1;
         d_valid = 1'b1;
         i_done  = 1'b0;
         d_done  = 1'b0;
         // Each valid drops on the falling edge after its ready was sampled
         do begin
            @(negedge clk);
            if (i_done) i_valid = 1'b0;
            if (d_done) d_valid = 1'b0;
            if (i_ready) i_done = 1'b1;
            if (d_ready) d_done = 1'b1;
         end while (!(i_done && d_done));
      end
      @(negedge clk);
      i_valid = 1'b0;
      d_valid = 1'b0;
      repeat (2) @(negedge clk);
      $display("Read errors: %0d, protocol errors: %0d, assertion failures: %0d",
               rd_errors, proto_errors, u_ext_mem.u_assertions.fail_cnt);
      if (rd_errors == 0 && proto_errors == 0 && u_ext_mem.u_assertions.fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (reset_cycles + n_pat*40) @(posedge clk);
      $display("Timeout: the DUT stopped answering requests");
      $display("Testbench failed");
      $finish;
   end

endmodule

// File: verification/ext_mem_patterns.txt
// i_addr d_addr d_wdata d_wstrb exp_i_rdata exp_d_rdata
// exp_d_rdata is ignored when d_wstrb is nonzero
00000000 00000800 00000000 00000000 C0DE0000 C0DE0200
00000000 00000800 00000000 00000000 C0DE0000 C0DE0200
00000004 00000804 11223344 00000003 C0DE0001 00000000
00000004 00000804 00000000 00000000 C0DE0001 C0DE3344
00000004 00000804 AABBCCDD 0000000C C0DE0001 00000000
00000004 00000804 00000000 00000000 C0DE0001 AABB3344
00000040 00000840 00000000 00000000 C0DE0010 C0DE0210
00000000 00000800 00000000 00000000 C0DE0000 C0DE0200
00000040 00000804 55667788 00000001 C0DE0010 00000000
00000040 00000844 00000000 00000000 C0DE0010 C0DE0211
00000008 00000804 00000000 00000000 C0DE0002 AABB3388
0000000C 0000080C FFFFFFFF 0000000F C0DE0003 00000000
0000000C 0000080C 00000000 00000000 C0DE0003 FFFFFFFF
00000100 00000900 00000000 00000000 C0DE0040 C0DE0240
000003FC 00000BFC 00000000 00000000 C0DE00FF C0DE02FF
000003FC 00000BFC 00008000 00000002 C0DE00FF 00000000
000003FC 00000BFC 00000000 00000000 C0DE00FF C0DE80FF
00000010 00000810 00000000 00000000 C0DE0004 C0DE0204
00000010 00000810 00000000 00000000 C0DE0004 C0DE0204
00000020 00000820 12345678 00000006 C0DE0008 00000000
00000020 00000820 00000000 00000000 C0DE0008 C0345608
00000000 00000800 00000000 00000000 C0DE0000 C0DE0200

// File: src.f
verilog/ext_mem_pkg.sv
verilog/mem_cache.sv
verilog/bus_merge.sv
verilog/ext_mem.sv
verification/clk_gen.sv
verification/ext_mem_checker.sv
verification/ext_mem_assertions.sv
verification/tb_ext_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then decide from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ext_mem -f src.f \
   -o sim_tb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation OK"
